// ==== src/vmul_defs.svh ====
`ifndef VMUL_DEFS_SVH
`define VMUL_DEFS_SVH

// Datapath word width in bits
`define VMUL_ELEN 64

// Instruction IDs tracked by the lane
`define VMUL_NR_VINSN 8

// Queue depths
`define VMUL_INSN_DEPTH 4
`define VMUL_RESULT_DEPTH 2

// Pipeline registers in each SIMD multiplier
`define VMUL_MUL_LAT 2

// Words per vector register
`define VMUL_VREG_WORDS 8

`endif

// ==== src/vec_pkg.sv ====
`include "vmul_defs.svh"

package vec_pkg;

  // One datapath word and its byte strobe
  typedef logic [`VMUL_ELEN-1:0]   elen_t;
  typedef logic [`VMUL_ELEN/8-1:0] strb_t;

  // Element width as log2 of its byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef logic [$clog2(`VMUL_NR_VINSN)-1:0] vid_t;

  // Element count of one instruction, up to 64
  typedef logic [6:0] vlen_t;

  // Word address in the register file
  typedef logic [7:0] vaddr_t;

endpackage

// ==== src/mfu_pkg.sv ====
package mfu_pkg;

  import vec_pkg::*;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMULHU = 2'd1,
    VMACC  = 2'd2
  } mul_op_e;

  // Instruction as held in the instruction queue
  typedef struct packed {
    mul_op_e    op;
    vew_e       vew;
    vlen_t      vl;
    logic [4:0] vd;
    vid_t       id;
    // Set for an unmasked instruction
    logic       vm;
    logic       use_scalar;
    elen_t      scalar_op;
    logic       use_vs1;
    logic       use_vs2;
    logic       use_vd;
  } mul_operation_t;

  // One result word on its way to the register file
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } rq_payload_t;

endpackage

// ==== src/vmul_ifs.sv ====
interface mul_issue_if import vec_pkg::*; import mfu_pkg::*; ();

  logic           valid;
  logic           ready;
  mul_operation_t operation;
  // Index 0 is vs1, 1 is vs2, 2 is vd
  elen_t [2:0]    operand;
  // Byte enables of the beat with the mask applied
  strb_t          mask;

  modport ctrl (
    output valid, operation, operand, mask,
    input  ready
  );

  modport dp (
    input  valid, operation, operand, mask,
    output ready
  );

endinterface

interface mul_result_if import vec_pkg::*; ();

  logic  valid;
  logic  ready;
  elen_t result;
  strb_t mask;
  // Width of the instruction in processing
  vew_e  vew;

  modport ctrl (
    input  valid, result, mask,
    output ready, vew
  );

  modport dp (
    output valid, result, mask,
    input  ready, vew
  );

endinterface

// ==== src/simd_mul.sv ====
`include "vmul_defs.svh"

module simd_mul import vec_pkg::*; import mfu_pkg::*; #(
  parameter vew_e        ElementWidth = EW64,
  parameter int unsigned NumPipeRegs  = `VMUL_MUL_LAT
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    valid_i,
  output logic    ready_o,
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  input  elen_t   operand_c_i,
  input  mul_op_e op_i,
  input  strb_t   mask_i,
  output logic    valid_o,
  input  logic    ready_i,
  output elen_t   result_o,
  output strb_t   mask_o
);

  localparam int unsigned Sew      = 8 << int'(ElementWidth);
  localparam int unsigned NumLanes = `VMUL_ELEN / Sew;

  elen_t product;

  // Lane operands are vs1, vs2 and vd
  for (genvar l = 0; l < NumLanes; l++) begin : gen_lane
    logic [Sew-1:0]   lane_a;
    logic [Sew-1:0]   lane_b;
    logic [Sew-1:0]   lane_c;
    logic [2*Sew-1:0] lane_prod;

    assign lane_a    = operand_a_i[l*Sew +: Sew];
    assign lane_b    = operand_b_i[l*Sew +: Sew];
    assign lane_c    = operand_c_i[l*Sew +: Sew];
    assign lane_prod = lane_a * lane_b;

    // Accumulation wraps at the element width
    assign product[l*Sew +: Sew] = (op_i == VMULHU) ? lane_prod[2*Sew-1:Sew] :
                                   (op_i == VMACC)  ? lane_prod[Sew-1:0] + lane_c :
                                                      lane_prod[Sew-1:0];
  end

  logic  [NumPipeRegs-1:0] valid_q;
  elen_t [NumPipeRegs-1:0] data_q;
  strb_t [NumPipeRegs-1:0] mask_q;

  // Stage inputs, index 0 being the multiplier input
  logic  [NumPipeRegs:0] in_valid;
  elen_t [NumPipeRegs:0] in_data;
  strb_t [NumPipeRegs:0] in_mask;
  logic  [NumPipeRegs:0] stage_ready;

  assign in_valid = {valid_q, valid_i};
  assign in_data  = {data_q, product};
  assign in_mask  = {mask_q, mask_i};

  // A stage moves when it is empty or the next one moves
  always_comb begin
    stage_ready[NumPipeRegs] = ready_i;
    for (int s = NumPipeRegs - 1; s >= 0; s--) begin
      stage_ready[s] = !valid_q[s] || stage_ready[s+1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int s = 0; s < NumPipeRegs; s++) begin
        if (stage_ready[s]) valid_q[s] <= in_valid[s];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int s = 0; s < NumPipeRegs; s++) begin
      if (stage_ready[s] && in_valid[s]) begin
        data_q[s] <= in_data[s];
        mask_q[s] <= in_mask[s];
      end
    end
  end

  assign ready_o  = stage_ready[0];
  assign valid_o  = valid_q[NumPipeRegs-1];
  assign result_o = data_q[NumPipeRegs-1];
  assign mask_o   = mask_q[NumPipeRegs-1];

  // A stalled output holds its word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> $stable(result_o));

endmodule

// ==== src/vmul_datapath.sv ====
`include "vmul_defs.svh"

module vmul_datapath import vec_pkg::*; import mfu_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  mul_issue_if.dp  issue_if,
  mul_result_if.dp result_if
);

  mul_operation_t issue_op;
  elen_t          scalar;
  elen_t          operand_a;

  assign issue_op = issue_if.operation;

  // Replicate the scalar element over the whole word
  always_comb begin
    case (issue_op.vew)
      EW8:     scalar = {8{issue_op.scalar_op[7:0]}};
      EW16:    scalar = {4{issue_op.scalar_op[15:0]}};
      EW32:    scalar = {2{issue_op.scalar_op[31:0]}};
      default: scalar = issue_op.scalar_op;
    endcase
  end

  assign operand_a = issue_op.use_scalar ? scalar : issue_if.operand[0];

  elen_t [3:0] unit_result;
  strb_t [3:0] unit_mask;
  logic  [3:0] unit_in_valid;
  logic  [3:0] unit_in_ready;
  logic  [3:0] unit_out_valid;
  logic  [3:0] unit_out_ready;

  // One multiplier per element width
  for (genvar w = 0; w < 4; w++) begin : gen_mul
    simd_mul #(
      .ElementWidth(vew_e'(w)),
      .NumPipeRegs (`VMUL_MUL_LAT)
    ) i_simd_mul (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .valid_i    (unit_in_valid[w]),
      .ready_o    (unit_in_ready[w]),
      .operand_a_i(operand_a),
      .operand_b_i(issue_if.operand[1]),
      .operand_c_i(issue_if.operand[2]),
      .op_i       (issue_op.op),
      .mask_i     (issue_if.mask),
      .valid_o    (unit_out_valid[w]),
      .ready_i    (unit_out_ready[w]),
      .result_o   (unit_result[w]),
      .mask_o     (unit_mask[w])
    );
  end

  // Beats enter at the issuing width and leave at the processing width
  always_comb begin
    unit_in_valid                 = '0;
    unit_in_valid[issue_op.vew]   = issue_if.valid;
    unit_out_ready                = '0;
    unit_out_ready[result_if.vew] = result_if.ready;
  end

  assign issue_if.ready   = unit_in_ready[issue_op.vew];
  assign result_if.valid  = unit_out_valid[result_if.vew];
  assign result_if.result = unit_result[result_if.vew];
  assign result_if.mask   = unit_mask[result_if.vew];

endmodule

// ==== src/vinsn_ctrl.sv ====
`include "vmul_defs.svh"

module vinsn_ctrl import vec_pkg::*; import mfu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  mul_operation_t            vfu_operation_i,
  input  logic                      vfu_operation_valid_i,
  output logic                      mfu_ready_o,
  input  elen_t [2:0]               operand_i,
  input  logic  [2:0]               operand_valid_i,
  output logic  [2:0]               operand_ready_o,
  input  strb_t                     mask_i,
  input  logic                      mask_valid_i,
  output logic                      mask_ready_o,
  output logic [`VMUL_NR_VINSN-1:0] vinsn_done_o,
  mul_issue_if.ctrl                 issue_if,
  mul_result_if.ctrl                result_if,
  output logic                      rq_push_o,
  output rq_payload_t               rq_payload_o,
  input  logic                      rq_full_i,
  input  logic                      rq_pop_i
);

  localparam int unsigned Depth = `VMUL_INSN_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);
  localparam int unsigned CntW  = PntW + 1;

  // Elements in the beat that starts at element done_cnt
  function automatic logic [3:0] beat_elems(vlen_t done_cnt, vlen_t vl, vew_e vew);
    vlen_t left;
    vlen_t full;
    left = vl - done_cnt;
    full = vlen_t'(4'd8 >> vew);
    return (full > left) ? left[3:0] : full[3:0];
  endfunction

  // Byte enables covering the first cnt elements of a word
  function automatic strb_t elem_be(logic [3:0] cnt, vew_e vew);
    strb_t      be;
    logic [3:0] bytes;
    bytes = cnt << vew;
    for (int b = 0; b < $bits(strb_t); b++) begin
      be[b] = (b < bytes);
    end
    return be;
  endfunction

  function automatic logic [PntW-1:0] next_pnt(logic [PntW-1:0] pnt);
    return (pnt == PntW'(Depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Circular queue with one pointer per phase
  mul_operation_t [Depth-1:0] insn_q;
  logic [PntW-1:0] accept_pnt_q, issue_pnt_q, proc_pnt_q, commit_pnt_q;
  logic [CntW-1:0] issue_cnt_q, proc_cnt_q, commit_cnt_q;

  // Elements already handled by each phase
  vlen_t issue_done_q, proc_done_q, commit_done_q;

  mul_operation_t issue_op, proc_op, commit_op;
  logic [3:0]     issue_n, proc_n, commit_n;
  logic           queue_full, accept, operands_ok;
  logic           issue_fire, issue_last, proc_fire, proc_last, commit_last;

  assign issue_op  = insn_q[issue_pnt_q];
  assign proc_op   = insn_q[proc_pnt_q];
  assign commit_op = insn_q[commit_pnt_q];

  // An instruction holds its slot until its last result is committed
  assign queue_full  = (commit_cnt_q == CntW'(Depth));
  assign mfu_ready_o = !queue_full;
  assign accept      = vfu_operation_valid_i && !queue_full;

  assign operands_ok = (operand_valid_i[0] || !issue_op.use_vs1) &&
                       (operand_valid_i[1] || !issue_op.use_vs2) &&
                       (operand_valid_i[2] || !issue_op.use_vd) &&
                       (mask_valid_i || issue_op.vm);

  assign issue_n            = beat_elems(issue_done_q, issue_op.vl, issue_op.vew);
  assign issue_if.valid     = (issue_cnt_q != '0) && operands_ok;
  assign issue_if.operation = issue_op;
  assign issue_if.operand   = operand_i;
  assign issue_if.mask      = elem_be(issue_n, issue_op.vew) & (issue_op.vm ? '1 : mask_i);

  assign issue_fire = issue_if.valid && issue_if.ready;
  assign issue_last = issue_fire && (issue_done_q + vlen_t'(issue_n) == issue_op.vl);

  // Operands and mask are popped as the beat enters the multiplier
  assign operand_ready_o = issue_fire ? {issue_op.use_vd, issue_op.use_vs2, issue_op.use_vs1}
                                      : 3'b000;
  assign mask_ready_o    = issue_fire && !issue_op.vm;

  assign result_if.vew   = proc_op.vew;
  assign result_if.ready = !rq_full_i;

  assign proc_n    = beat_elems(proc_done_q, proc_op.vl, proc_op.vew);
  assign proc_fire = result_if.valid && result_if.ready && (proc_cnt_q != '0);
  assign proc_last = proc_fire && (proc_done_q + vlen_t'(proc_n) == proc_op.vl);

  assign rq_push_o          = proc_fire;
  assign rq_payload_o.id    = proc_op.id;
  // Register base plus beat index
  assign rq_payload_o.addr  = vaddr_t'(proc_op.vd) * vaddr_t'(`VMUL_VREG_WORDS) +
                              vaddr_t'(proc_done_q >> (3 - int'(proc_op.vew)));
  assign rq_payload_o.wdata = result_if.result;
  assign rq_payload_o.be    = elem_be(proc_n, proc_op.vew) & result_if.mask;

  assign commit_n    = beat_elems(commit_done_q, commit_op.vl, commit_op.vew);
  assign commit_last = rq_pop_i && (commit_cnt_q != '0) &&
                       (commit_done_q + vlen_t'(commit_n) == commit_op.vl);

  always_comb begin
    vinsn_done_o = '0;
    if (commit_last) begin
      vinsn_done_o[commit_op.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q  <= '0;
      issue_pnt_q   <= '0;
      proc_pnt_q    <= '0;
      commit_pnt_q  <= '0;
      issue_cnt_q   <= '0;
      proc_cnt_q    <= '0;
      commit_cnt_q  <= '0;
      issue_done_q  <= '0;
      proc_done_q   <= '0;
      commit_done_q <= '0;
    end else begin
      if (accept) accept_pnt_q <= next_pnt(accept_pnt_q);
      if (issue_last) issue_pnt_q <= next_pnt(issue_pnt_q);
      if (proc_last) proc_pnt_q <= next_pnt(proc_pnt_q);
      if (commit_last) commit_pnt_q <= next_pnt(commit_pnt_q);

      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_last);
      proc_cnt_q   <= proc_cnt_q + CntW'(accept) - CntW'(proc_last);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(commit_last);

      if (issue_fire) begin
        issue_done_q <= issue_last ? '0 : issue_done_q + vlen_t'(issue_n);
      end
      if (proc_fire) begin
        proc_done_q <= proc_last ? '0 : proc_done_q + vlen_t'(proc_n);
      end
      if (rq_pop_i) begin
        commit_done_q <= commit_last ? '0 : commit_done_q + vlen_t'(commit_n);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) insn_q[accept_pnt_q] <= vfu_operation_i;
  end

  // Issue stays ahead of processing, processing ahead of commit, and no slot is overfilled
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_cnt_q <= proc_cnt_q) && (proc_cnt_q <= commit_cnt_q) &&
    (commit_cnt_q <= CntW'(Depth)));

  // Done only for an instruction whose beats have all left the multiplier
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (vinsn_done_o != '0) |-> (proc_cnt_q < commit_cnt_q));

endmodule

// ==== src/result_queue.sv ====
`include "vmul_defs.svh"

module result_queue import mfu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        push_i,
  input  rq_payload_t payload_i,
  output logic        full_o,
  output logic        req_o,
  output rq_payload_t payload_o,
  input  logic        gnt_i,
  output logic        pop_o
);

  localparam int unsigned Depth = `VMUL_RESULT_DEPTH;
  localparam int unsigned PntW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = PntW + 1;

  rq_payload_t [Depth-1:0] mem_q;
  logic [PntW-1:0]         wr_pnt_q;
  logic [PntW-1:0]         rd_pnt_q;
  logic [CntW-1:0]         cnt_q;

  // The head entry is always on the request lines
  assign full_o    = (cnt_q == CntW'(Depth));
  assign req_o     = (cnt_q != '0);
  assign payload_o = mem_q[rd_pnt_q];
  assign pop_o     = req_o && gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_pnt_q <= (wr_pnt_q == PntW'(Depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      if (pop_o) rd_pnt_q <= (rd_pnt_q == PntW'(Depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      cnt_q <= cnt_q + CntW'(push_i) - CntW'(pop_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_pnt_q] <= payload_i;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);

  // The register file grants only a pending request
  assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_i |-> req_o);

endmodule

// ==== src/vmul_unit.sv ====
`include "vmul_defs.svh"

module vmul_unit import vec_pkg::*; import mfu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  mul_operation_t            vfu_operation_i,
  input  logic                      vfu_operation_valid_i,
  output logic                      mfu_ready_o,
  input  elen_t [2:0]               operand_i,
  input  logic  [2:0]               operand_valid_i,
  output logic  [2:0]               operand_ready_o,
  input  strb_t                     mask_i,
  input  logic                      mask_valid_i,
  output logic                      mask_ready_o,
  output logic                      result_req_o,
  output vid_t                      result_id_o,
  output vaddr_t                    result_addr_o,
  output elen_t                     result_wdata_o,
  output strb_t                     result_be_o,
  input  logic                      result_gnt_i,
  output logic [`VMUL_NR_VINSN-1:0] vinsn_done_o
);

  mul_issue_if  issue_if ();
  mul_result_if result_if ();

  logic        rq_push;
  logic        rq_full;
  logic        rq_pop;
  rq_payload_t rq_in;
  rq_payload_t rq_head;

  vinsn_ctrl i_vinsn_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .vfu_operation_i      (vfu_operation_i),
    .vfu_operation_valid_i(vfu_operation_valid_i),
    .mfu_ready_o          (mfu_ready_o),
    .operand_i            (operand_i),
    .operand_valid_i      (operand_valid_i),
    .operand_ready_o      (operand_ready_o),
    .mask_i               (mask_i),
    .mask_valid_i         (mask_valid_i),
    .mask_ready_o         (mask_ready_o),
    .vinsn_done_o         (vinsn_done_o),
    .issue_if             (issue_if.ctrl),
    .result_if            (result_if.ctrl),
    .rq_push_o            (rq_push),
    .rq_payload_o         (rq_in),
    .rq_full_i            (rq_full),
    .rq_pop_i             (rq_pop)
  );

  vmul_datapath i_vmul_datapath (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .issue_if (issue_if.dp),
    .result_if(result_if.dp)
  );

  result_queue i_result_queue (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (rq_push),
    .payload_i(rq_in),
    .full_o   (rq_full),
    .req_o    (result_req_o),
    .payload_o(rq_head),
    .gnt_i    (result_gnt_i),
    .pop_o    (rq_pop)
  );

  assign result_id_o    = rq_head.id;
  assign result_addr_o  = rq_head.addr;
  assign result_wdata_o = rq_head.wdata;
  assign result_be_o    = rq_head.be;

endmodule

// ==== sim/vmul_checks.svh ====
`ifndef VMUL_CHECKS_SVH
`define VMUL_CHECKS_SVH

task automatic check_word(input elen_t got, input elen_t exp, input string what);
  if (got !== exp) begin
    $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    err_value++;
  end
endtask

task automatic check_strb(input strb_t got, input strb_t exp, input string what);
  if (got !== exp) begin
    $display("** Error at %0t ns: %s are %b, expected %b", $time, what, got, exp);
    err_value++;
  end
endtask

task automatic check_addr(input vaddr_t got, input vaddr_t exp, input string what);
  if (got !== exp) begin
    $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    err_value++;
  end
endtask

task automatic check_id(input vid_t got, input vid_t exp, input string what);
  if (got !== exp) begin
    $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    err_value++;
  end
endtask

// Mask ready above the three operand ready bits
task automatic check_ready(input logic [3:0] got, input logic [3:0] exp, input string what);
  if (got !== exp) begin
    $display("** Error at %0t ns: %s are %b, expected %b", $time, what, got, exp);
    err_value++;
  end
endtask

// vs2 is always read, vs1 unless the scalar replaces it, vd only for MACC
function automatic mul_operation_t build_insn(mul_op_e op, vew_e vew, int vl, int vd,
                                              logic vm, logic use_scalar, elen_t scalar);
  mul_operation_t o;
  o            = '0;
  o.op         = op;
  o.vew        = vew;
  o.vl         = vlen_t'(vl);
  o.vd         = 5'(vd);
  o.id         = vid_t'(next_id);
  o.vm         = vm;
  o.use_scalar = use_scalar;
  o.scalar_op  = scalar;
  o.use_vs1    = !use_scalar;
  o.use_vs2    = 1'b1;
  o.use_vd     = (op == VMACC);
  next_id++;
  return o;
endfunction

task automatic send_insn(input mul_operation_t o);
  @(posedge clk_i);
  vfu_operation_i       <= o;
  vfu_operation_valid_i <= 1'b1;
  do @(posedge clk_i); while (!mfu_ready_o);
  vfu_operation_valid_i <= 1'b0;
endtask

// Wait until every accepted instruction has signalled done
task automatic wait_idle(input string name);
  do @(negedge clk_i); while (done_cnt != accept_cnt || exp_q.size() != 0);
  repeat (4) @(negedge clk_i);
  if (result_req_o || exp_q.size() != 0 || issue_q.size() != 0) begin
    $display("Leftover results or beats after %s", name);
    err_other++;
  end
endtask

task automatic test_reset();
  @(negedge clk_i);
  if (!mfu_ready_o || result_req_o || vinsn_done_o != '0 ||
      operand_ready_o != 3'b000 || mask_ready_o) begin
    $display("Outputs after reset are wrong: ready %b req %b done %b opnd %b mask %b",
             mfu_ready_o, result_req_o, vinsn_done_o, operand_ready_o, mask_ready_o);
    err_other++;
  end
endtask

task automatic test_vmul_widths();
  gnt_pattern <= 8'hff;
  send_insn(build_insn(VMUL, EW8, 13, 1, 1'b1, 1'b0, '0));
  send_insn(build_insn(VMUL, EW16, 10, 2, 1'b1, 1'b0, '0));
  send_insn(build_insn(VMUL, EW32, 7, 3, 1'b1, 1'b0, '0));
  send_insn(build_insn(VMUL, EW64, 3, 4, 1'b1, 1'b0, '0));
  wait_idle("test_vmul_widths");
endtask

task automatic test_scalar_macc();
  gnt_pattern <= 8'b1101_0110;
  send_insn(build_insn(VMACC, EW16, 9, 5, 1'b1, 1'b1, 64'h0123_4567_89ab_f00d));
  send_insn(build_insn(VMACC, EW32, 5, 6, 1'b1, 1'b1, 64'hdead_beef_8000_0003));
  wait_idle("test_scalar_macc");
endtask

task automatic test_mulhu_masked();
  gnt_pattern <= 8'b0111_1011;
  send_insn(build_insn(VMULHU, EW8, 20, 7, 1'b0, 1'b0, '0));
  send_insn(build_insn(VMULHU, EW32, 6, 8, 1'b0, 1'b0, '0));
  wait_idle("test_mulhu_masked");
endtask

// Four instructions fill the queue while the grant is held low
task automatic test_backpressure();
  mul_operation_t fifth;
  int             k;
  gnt_pattern <= 8'h00;
  for (k = 0; k < 4; k++) begin
    send_insn(build_insn(VMUL, EW16, 6, 9 + k, 1'b1, 1'b0, '0));
  end
  fifth = build_insn(VMUL, EW16, 6, 13, 1'b1, 1'b0, '0);
  @(posedge clk_i);
  if (mfu_ready_o) begin
    $display("mfu_ready_o stayed high with four instructions queued");
    err_other++;
  end
  vfu_operation_i       <= fifth;
  vfu_operation_valid_i <= 1'b1;
  repeat (30) begin
    @(posedge clk_i);
    if (mfu_ready_o) begin
      $display("The fifth instruction was accepted while the grant was held");
      err_other++;
    end
  end
  gnt_pattern <= 8'hff;
  do @(posedge clk_i); while (!mfu_ready_o);
  vfu_operation_valid_i <= 1'b0;
  wait_idle("test_backpressure");
endtask

`endif

// ==== sim/tb_vmul_unit.sv ====
`include "vmul_defs.svh"

module tb_vmul_unit import vec_pkg::*; import mfu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Beats of all tests: widths 12, scalar MACC 6, masked MULHU 6, back-pressure 10
  localparam int TotalBeats = 34;
  localparam int CycleLimit = 20 * TotalBeats + 200;

  logic                      clk_i;
  logic                      rst_ni;
  mul_operation_t            vfu_operation_i;
  logic                      vfu_operation_valid_i;
  logic                      mfu_ready_o;
  elen_t [2:0]               operand_i = {64'h1357_9bdf_0246_8ace, 64'hfedc_ba98_7654_3210,
                                          64'h0f1e_2d3c_4b5a_6978};
  logic  [2:0]               operand_valid_i;
  logic  [2:0]               operand_ready_o;
  strb_t                     mask_i = 8'ha5;
  logic                      mask_valid_i;
  logic                      mask_ready_o;
  logic                      result_req_o;
  vid_t                      result_id_o;
  vaddr_t                    result_addr_o;
  elen_t                     result_wdata_o;
  strb_t                     result_be_o;
  logic                      result_gnt_i = 1'b0;
  logic [`VMUL_NR_VINSN-1:0] vinsn_done_o;

  integer         seed = 32'h275a_93b3;
  int             err_value;
  int             err_other;
  int             accept_cnt;
  int             done_cnt;
  int             next_id;
  int             beat_idx;
  logic [7:0]     gnt_pattern;
  logic [2:0]     gnt_phase = 3'd0;
  // Accepted instructions not yet fully issued
  mul_operation_t issue_q[$];
  // Expected results in order, with a flag for the last beat of each instruction
  rq_payload_t    exp_q[$];
  bit             last_q[$];

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  vmul_unit dut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .vfu_operation_i      (vfu_operation_i),
    .vfu_operation_valid_i(vfu_operation_valid_i),
    .mfu_ready_o          (mfu_ready_o),
    .operand_i            (operand_i),
    .operand_valid_i      (operand_valid_i),
    .operand_ready_o      (operand_ready_o),
    .mask_i               (mask_i),
    .mask_valid_i         (mask_valid_i),
    .mask_ready_o         (mask_ready_o),
    .result_req_o         (result_req_o),
    .result_id_o          (result_id_o),
    .result_addr_o        (result_addr_o),
    .result_wdata_o       (result_wdata_o),
    .result_be_o          (result_be_o),
    .result_gnt_i         (result_gnt_i),
    .vinsn_done_o         (vinsn_done_o)
  );

  `include "vmul_checks.svh"

  // Scalar element copied into every lane of the word
  function automatic elen_t replicate(elen_t s, vew_e vew);
    logic [127:0] acc;
    logic [127:0] emask;
    int           sew;
    int           l;
    sew   = 8 << int'(vew);
    emask = (128'd1 << sew) - 128'd1;
    acc   = '0;
    for (l = 0; l < 64 / sew; l++) begin
      acc = acc | (({64'd0, s} & emask) << (l * sew));
    end
    return elen_t'(acc);
  endfunction

  // Lane results with 128-bit products, wrapped to the element width
  function automatic elen_t expect_word(mul_op_e op, vew_e vew, elen_t a, elen_t b, elen_t c);
    logic [127:0] emask;
    logic [127:0] x;
    logic [127:0] y;
    logic [127:0] z;
    logic [127:0] prod;
    logic [127:0] lane;
    logic [127:0] acc;
    int           sew;
    int           l;
    sew   = 8 << int'(vew);
    emask = (128'd1 << sew) - 128'd1;
    acc   = '0;
    for (l = 0; l < 64 / sew; l++) begin
      x    = ({64'd0, a} >> (l * sew)) & emask;
      y    = ({64'd0, b} >> (l * sew)) & emask;
      z    = ({64'd0, c} >> (l * sew)) & emask;
      prod = x * y;
      case (op)
        VMULHU:  lane = (prod >> sew) & emask;
        VMACC:   lane = (prod + z) & emask;
        default: lane = prod & emask;
      endcase
      acc = acc | (lane << (l * sew));
    end
    return elen_t'(acc);
  endfunction

  // Bytes of the first nelem elements, masked for vm = 0
  function automatic strb_t expect_be(vew_e vew, int nelem, logic vm, strb_t m);
    strb_t be;
    int    bpe;
    int    b;
    bpe = 1 << int'(vew);
    for (b = 0; b < 8; b++) begin
      be[b] = ((b / bpe) < nelem);
    end
    return vm ? be : (be & m);
  endfunction

  // Accepted instructions, beat log, reference results and operand refresh
  always @(posedge clk_i) begin
    mul_operation_t op;
    rq_payload_t    e;
    elen_t          a;
    int             per;
    int             n;
    int             i;
    if (rst_ni && vfu_operation_valid_i && mfu_ready_o) begin
      issue_q.push_back(vfu_operation_i);
      accept_cnt++;
    end
    if (rst_ni && operand_ready_o[1]) begin
      if (issue_q.size() == 0) begin
        $display("A beat was issued with no accepted instruction at %0t ns", $time);
        err_other++;
      end else begin
        op  = issue_q[0];
        check_ready({mask_ready_o, operand_ready_o},
                    {!op.vm, op.use_vd, op.use_vs2, op.use_vs1}, "mask and operand ready");
        per = 8 >> int'(op.vew);
        n   = int'(op.vl) - beat_idx * per;
        if (n > per) n = per;
        a       = op.use_scalar ? replicate(op.scalar_op, op.vew) : operand_i[0];
        e.id    = op.id;
        e.addr  = vaddr_t'(int'(op.vd) * `VMUL_VREG_WORDS + beat_idx);
        e.wdata = expect_word(op.op, op.vew, a, operand_i[1], operand_i[2]);
        e.be    = expect_be(op.vew, n, op.vm, mask_i);
        exp_q.push_back(e);
        last_q.push_back(beat_idx * per + n == int'(op.vl));
        if (beat_idx * per + n == int'(op.vl)) begin
          void'(issue_q.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
    end else if (rst_ni && (operand_ready_o != 3'b000 || mask_ready_o)) begin
      $display("An operand or the mask was acknowledged with no beat issued at %0t ns", $time);
      err_other++;
    end
    for (i = 0; i < 3; i++) begin
      if (operand_ready_o[i]) operand_i[i] <= {$random(seed), $random(seed)};
    end
    if (mask_ready_o) mask_i <= strb_t'($random(seed));
  end

  // Grant driver and result checker
  always @(posedge clk_i) begin
    rq_payload_t               e;
    bit                        is_last;
    logic [`VMUL_NR_VINSN-1:0] want_done;
    want_done = '0;
    if (rst_ni && result_req_o && result_gnt_i) begin
      if (exp_q.size() == 0) begin
        $display("A result was granted with no beat left to expect at %0t ns", $time);
        err_other++;
      end else begin
        e       = exp_q.pop_front();
        is_last = last_q.pop_front();
        check_id(result_id_o, e.id, "result id");
        check_addr(result_addr_o, e.addr, "result address");
        check_word(result_wdata_o, e.wdata, "result data");
        check_strb(result_be_o, e.be, "byte enables");
        if (is_last) want_done[e.id] = 1'b1;
      end
    end
    if (rst_ni && vinsn_done_o != want_done) begin
      if (vinsn_done_o == '0) begin
        $display("Missing done pulse for instruction %0d at %0t ns", e.id, $time);
      end else begin
        $display("Done pulse for the wrong instruction at %0t ns: got %b, expected %b",
                 $time, vinsn_done_o, want_done);
      end
      err_other++;
    end
    if (rst_ni && vinsn_done_o != '0) done_cnt++;
    // A grant only follows a cycle without one, so the request is still pending
    result_gnt_i <= result_req_o && !result_gnt_i && gnt_pattern[gnt_phase];
    gnt_phase    <= gnt_phase + 3'd1;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_ni                = 1'b0;
    vfu_operation_i       = '0;
    vfu_operation_valid_i = 1'b0;
    operand_valid_i       = 3'b000;
    mask_valid_i          = 1'b0;
    gnt_pattern           = 8'hff;
    repeat (10) @(posedge clk_i);
    rst_ni          <= 1'b1;
    operand_valid_i <= 3'b111;
    mask_valid_i    <= 1'b1;
    test_reset();
    test_vmul_widths();
    test_scalar_macc();
    test_mulhu_masked();
    test_backpressure();
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+src
+incdir+sim
src/vec_pkg.sv
src/mfu_pkg.sv
src/vmul_ifs.sv
src/simd_mul.sv
src/vmul_datapath.sv
src/vinsn_ctrl.sv
src/result_queue.sv
src/vmul_unit.sv
sim/tb_vmul_unit.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module tb_vmul_unit -f files.f

run: compile
	./obj_dir/Vtb_vmul_unit | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
